//--- control_pkg.sv
// Control package with field types, CPU state enum, opcode, funct, ALU, extend and lane codes
`default_nettype none

package control_pkg;

    typedef logic [5:0] opcode_t;     // Primary opcode
    typedef logic [5:0] funct_t;      // R-type function field
    typedef logic [4:0] rt_field_t;   // REGIMM rt field
    typedef logic [3:0] alu_op_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [2:0] extend_op_t;
    typedef logic [1:0] md_op_t;

    typedef enum logic [3:0] {
        halt   = 4'd0,
        fetch  = 4'd1,
        decode = 4'd2,
        exec1  = 4'd3,
        exec2  = 4'd4
    } cpu_state_t;

    // Primary opcodes
    localparam opcode_t op_rtype  = 6'b000000;
    localparam opcode_t op_regimm = 6'b000001;
    localparam opcode_t op_j      = 6'b000010;
    localparam opcode_t op_jal    = 6'b000011;
    localparam opcode_t op_beq    = 6'b000100;
    localparam opcode_t op_bne    = 6'b000101;
    localparam opcode_t op_blez   = 6'b000110;
    localparam opcode_t op_bgtz   = 6'b000111;
    localparam opcode_t op_addiu  = 6'b001001;
    localparam opcode_t op_slti   = 6'b001010;
    localparam opcode_t op_sltiu  = 6'b001011;
    localparam opcode_t op_andi   = 6'b001100;
    localparam opcode_t op_ori    = 6'b001101;
    localparam opcode_t op_xori   = 6'b001110;
    localparam opcode_t op_lui    = 6'b001111;
    localparam opcode_t op_lb     = 6'b100000;
    localparam opcode_t op_lh     = 6'b100001;
    localparam opcode_t op_lw     = 6'b100011;
    localparam opcode_t op_lbu    = 6'b100100;
    localparam opcode_t op_lhu    = 6'b100101;
    localparam opcode_t op_sb     = 6'b101000;
    localparam opcode_t op_sh     = 6'b101001;
    localparam opcode_t op_sw     = 6'b101011;

    // R-type function codes
    localparam funct_t fn_sll   = 6'b000000;
    localparam funct_t fn_srl   = 6'b000010;
    localparam funct_t fn_sra   = 6'b000011;
    localparam funct_t fn_sllv  = 6'b000100;
    localparam funct_t fn_srlv  = 6'b000110;
    localparam funct_t fn_srav  = 6'b000111;
    localparam funct_t fn_jr    = 6'b001000;
    localparam funct_t fn_jalr  = 6'b001001;
    localparam funct_t fn_mfhi  = 6'b010000;
    localparam funct_t fn_mthi  = 6'b010001;
    localparam funct_t fn_mflo  = 6'b010010;
    localparam funct_t fn_mtlo  = 6'b010011;
    localparam funct_t fn_mult  = 6'b011000;
    localparam funct_t fn_multu = 6'b011001;
    localparam funct_t fn_div   = 6'b011010;
    localparam funct_t fn_divu  = 6'b011011;
    localparam funct_t fn_addu  = 6'b100001;
    localparam funct_t fn_subu  = 6'b100011;
    localparam funct_t fn_and   = 6'b100100;
    localparam funct_t fn_or    = 6'b100101;
    localparam funct_t fn_xor   = 6'b100110;
    localparam funct_t fn_slt   = 6'b101010;
    localparam funct_t fn_sltu  = 6'b101011;

    // ALU control codes
    localparam alu_op_t alu_add    = 4'b0000;
    localparam alu_op_t alu_sub_eq = 4'b0001;
    localparam alu_op_t alu_funct  = 4'b0010;   // ALU decodes the funct field itself
    localparam alu_op_t alu_and    = 4'b0100;
    localparam alu_op_t alu_or     = 4'b0101;
    localparam alu_op_t alu_xor    = 4'b0110;
    localparam alu_op_t alu_slt    = 4'b0111;
    localparam alu_op_t alu_ne     = 4'b1000;
    localparam alu_op_t alu_gtz    = 4'b1001;
    localparam alu_op_t alu_lez    = 4'b1010;
    localparam alu_op_t alu_regimm = 4'b1011;
    localparam alu_op_t alu_sltu   = 4'b1100;

    // Load extension, bit 1 selects byte, bit 0 selects sign
    localparam extend_op_t ext_none   = 3'b000;
    localparam extend_op_t ext_half_u = 3'b100;
    localparam extend_op_t ext_half_s = 3'b101;
    localparam extend_op_t ext_byte_u = 3'b110;
    localparam extend_op_t ext_byte_s = 3'b111;

    // Mult/div unit operations
    localparam md_op_t md_mthi = 2'b00;
    localparam md_op_t md_mtlo = 2'b01;
    localparam md_op_t md_mult = 2'b10;
    localparam md_op_t md_div  = 2'b11;

    // REGIMM linking branches
    localparam rt_field_t rt_bltzal = 5'b10000;
    localparam rt_field_t rt_bgezal = 5'b10001;

    // Bus byte lane patterns
    localparam byte_en_t be_word = 4'b1111;
    localparam byte_en_t be_byte = 4'b0001;
    localparam byte_en_t be_half = 4'b0011;

endpackage

`default_nettype wire

//--- cpu_state_seq.sv
// CPU state sequencer with waitrequest stalls and pcwrite strobe
`timescale 1ns/100ps
`default_nettype none

module cpu_state_seq (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               waitrequest,
    input  wire logic               memread,
    output control_pkg::cpu_state_t state,
    output logic                    pcwrite
);

    import control_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= halt;
        end else begin
            case (state)
                halt: state <= fetch;
                fetch: begin
                    if (!waitrequest) begin   // Instruction word has arrived
                        state <= decode;
                    end
                end
                decode: state <= exec1;
                exec1: begin
                    if (!memread || !waitrequest) begin   // Only a load read can stall here
                        state <= exec2;
                    end
                end
                exec2: begin
                    if (!waitrequest) begin
                        state <= fetch;
                    end
                end
                default: state <= halt;
            endcase
        end
    end

    // PC advances on the last cycle of the instruction
    assign pcwrite = (state == exec2) && !waitrequest;

endmodule

`default_nettype wire

//--- funct_decoder.sv
// R-type funct decoder for function classes and mult/div controls
`timescale 1ns/100ps
`default_nettype none

module funct_decoder (
    input  wire control_pkg::funct_t fun,
    output logic                     arith,
    output logic                     regjump,
    output logic                     mult_div,
    output logic                     div_mult_signed,
    output logic                     hitoreg,
    output logic                     lotoreg,
    output logic                     jalr,
    output control_pkg::md_op_t      div_mult_op
);

    import control_pkg::*;

    always_comb begin
        arith           = 1'b0;
        regjump         = 1'b0;
        mult_div        = 1'b0;
        div_mult_signed = 1'b0;
        hitoreg         = 1'b0;
        lotoreg         = 1'b0;
        jalr            = 1'b0;
        div_mult_op     = md_mthi;
        case (fun)
            fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sltu,
            fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav: begin
                arith = 1'b1;   // Plain register result
            end
            fn_mfhi: begin
                arith   = 1'b1;
                hitoreg = 1'b1;
            end
            fn_mflo: begin
                arith   = 1'b1;
                lotoreg = 1'b1;
            end
            fn_jr: regjump = 1'b1;
            fn_jalr: begin
                arith   = 1'b1;   // Return address goes to rd
                regjump = 1'b1;
                jalr    = 1'b1;
            end
            fn_mthi: mult_div = 1'b1;
            fn_mtlo: begin
                mult_div    = 1'b1;
                div_mult_op = md_mtlo;
            end
            fn_mult, fn_multu: begin
                mult_div        = 1'b1;
                div_mult_op     = md_mult;
                div_mult_signed = (fun == fn_mult);
            end
            fn_div, fn_divu: begin
                mult_div        = 1'b1;
                div_mult_op     = md_div;
                div_mult_signed = (fun == fn_div);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- opcode_decoder.sv
// Opcode decoder for datapath steering and instruction kind flags
`timescale 1ns/100ps
`default_nettype none

module opcode_decoder (
    input  wire control_pkg::cpu_state_t state,
    input  wire control_pkg::opcode_t    opcode,
    input  wire control_pkg::rt_field_t  branch_func,
    input  wire logic                    regjump,
    input  wire logic                    jalr,
    input  wire logic                    arith,
    output control_pkg::alu_op_t         alu_op,
    output logic                         alu_src,
    output logic                         signed_imm,
    output logic                         jump,
    output logic                         branch,
    output logic                         regdst,
    output logic                         memtoreg,
    output logic                         regtojump,
    output logic                         link,
    output logic                         reg_link,
    output logic                         loadimmed,
    output control_pkg::extend_op_t      extend_op,
    output logic                         is_load,
    output logic                         store_byte,
    output logic                         store_half,
    output logic                         is_store,
    output logic                         writes_reg
);

    import control_pkg::*;

    logic branchlink;

    assign branchlink = (branch_func == rt_bltzal) || (branch_func == rt_bgezal);

    always_comb begin
        alu_op     = alu_add;
        alu_src    = 1'b0;
        signed_imm = 1'b0;
        jump       = 1'b0;
        branch     = 1'b0;
        regdst     = 1'b0;
        memtoreg   = 1'b0;
        regtojump  = 1'b0;
        link       = 1'b0;
        reg_link   = 1'b0;
        loadimmed  = 1'b0;
        extend_op  = ext_none;
        is_load    = 1'b0;
        store_byte = 1'b0;
        store_half = 1'b0;
        is_store   = 1'b0;
        writes_reg = 1'b0;
        if (state == exec1 || state == exec2) begin   // Fetch and decode keep defaults
            // Every kept opcode except R-type and the register branches takes an immediate
            alu_src = !(opcode inside {op_rtype, op_beq, op_bne, op_j, op_jal});
            case (opcode)
                op_rtype: begin
                    alu_op     = alu_funct;
                    regdst     = 1'b1;
                    jump       = regjump;
                    regtojump  = regjump;
                    link       = jalr;
                    reg_link   = jalr;
                    writes_reg = arith;
                end
                op_addiu, op_slti, op_sltiu: begin
                    signed_imm = 1'b1;
                    writes_reg = 1'b1;
                    alu_op     = (opcode == op_slti)  ? alu_slt  :
                                 (opcode == op_sltiu) ? alu_sltu : alu_add;
                end
                op_andi, op_ori, op_xori: begin
                    writes_reg = 1'b1;
                    alu_op     = (opcode == op_andi) ? alu_and :
                                 (opcode == op_ori)  ? alu_or  : alu_xor;
                end
                op_lui: begin
                    loadimmed  = 1'b1;
                    is_load    = 1'b1;   // Issues a bus read like a load
                    writes_reg = 1'b1;
                end
                op_beq: begin
                    alu_op = alu_sub_eq;
                    branch = 1'b1;
                end
                op_bne: begin
                    alu_op = alu_ne;
                    branch = 1'b1;
                end
                op_bgtz: begin
                    alu_op = alu_gtz;
                    branch = 1'b1;
                end
                op_blez: begin
                    alu_op = alu_lez;
                    branch = 1'b1;
                end
                op_regimm: begin
                    alu_op     = alu_regimm;   // ALU picks the condition from rt
                    branch     = 1'b1;
                    link       = branchlink;
                    writes_reg = branchlink;
                end
                op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                    is_load    = 1'b1;
                    writes_reg = 1'b1;
                    memtoreg   = (opcode == op_lw);
                    case (opcode)
                        op_lb:   extend_op = ext_byte_s;
                        op_lbu:  extend_op = ext_byte_u;
                        op_lh:   extend_op = ext_half_s;
                        op_lhu:  extend_op = ext_half_u;
                        default: extend_op = ext_none;
                    endcase
                end
                op_sb, op_sh, op_sw: begin
                    regdst     = 1'b1;
                    is_store   = 1'b1;
                    store_byte = (opcode == op_sb);
                    store_half = (opcode == op_sh);
                end
                op_j: jump = 1'b1;
                op_jal: begin
                    jump       = 1'b1;
                    link       = 1'b1;   // Return address into r31
                    writes_reg = 1'b1;
                end
                default: ;   // Unknown opcode acts as a no-op
            endcase
        end
    end

endmodule

`default_nettype wire

//--- state_gate.sv
// State gating of memory, register and instruction register strobes, plus store byte lanes
`timescale 1ns/100ps
`default_nettype none

module state_gate (
    input  wire control_pkg::cpu_state_t state,
    input  wire logic                    is_load,
    input  wire logic                    is_store,
    input  wire logic                    store_byte,
    input  wire logic                    store_half,
    input  wire logic                    writes_reg,
    input  wire logic                    mult_div,
    input  wire logic [1:0]              address_align,
    output logic                         memread,
    output logic                         memwrite,
    output logic                         regwrite,
    output logic                         inwrite,
    output logic                         pctoadd,
    output logic                         div_mult_en,
    output logic                         bytewrite,
    output logic                         halfwrite,
    output control_pkg::byte_en_t        byteenable
);

    import control_pkg::*;

    logic in_exec;

    assign in_exec = (state == exec1) || (state == exec2);

    // Reads stall the bus, so only fetch and load execution request one
    assign memread     = (state == fetch) || ((state == exec1) && is_load);
    assign inwrite     = (state == decode);
    assign pctoadd     = (state == fetch) || (state == decode);   // PC drives the address
    assign div_mult_en = (state == exec1) && mult_div;
    assign regwrite    = (state == exec2) && writes_reg;   // Result is settled by exec2
    assign memwrite    = (state == exec2) && is_store;

    always_comb begin
        byteenable = be_word;
        bytewrite  = 1'b0;
        halfwrite  = 1'b0;
        if (in_exec && store_byte) begin
            byteenable = be_byte << address_align;
            bytewrite  = 1'b1;
            halfwrite  = 1'b1;
        end else if (in_exec && store_half) begin
            byteenable = be_half << address_align;   // Upper lane drops off at offset 3
            halfwrite  = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- control_unit.sv
// Control unit top joining the state sequencer, funct and opcode decoders and state gating
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire control_pkg::opcode_t   opcode,
    input  wire control_pkg::funct_t    fun,
    input  wire control_pkg::rt_field_t branch_func,
    input  wire logic                   waitrequest,
    input  wire logic [1:0]             address_align,
    output control_pkg::byte_en_t       byteenable,
    output logic                        bytewrite,
    output logic                        halfwrite,
    output control_pkg::alu_op_t        alu_op,
    output logic                        alu_src,
    output logic                        signed_imm,
    output logic                        jump,
    output logic                        branch,
    output logic                        memread,
    output logic                        memwrite,
    output logic                        regdst,
    output logic                        memtoreg,
    output logic                        regwrite,
    output logic                        inwrite,
    output logic                        pctoadd,
    output logic                        pcwrite,
    output logic                        regtojump,
    output logic                        div_mult_en,
    output logic                        div_mult_signed,
    output control_pkg::md_op_t         div_mult_op,
    output logic                        hitoreg,
    output logic                        lotoreg,
    output logic                        link,
    output logic                        reg_link,
    output logic                        loadimmed,
    output control_pkg::extend_op_t     extend_op,
    output control_pkg::cpu_state_t     state
);

    logic arith;        // R-type function writes rd
    logic regjump;
    logic mult_div;
    logic jalr;
    logic is_load;
    logic is_store;
    logic store_byte;
    logic store_half;
    logic writes_reg;

    cpu_state_seq u_seq (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .memread     (memread),
        .state       (state),
        .pcwrite     (pcwrite)
    );

    funct_decoder u_funct (
        .fun             (fun),
        .arith           (arith),
        .regjump         (regjump),
        .mult_div        (mult_div),
        .div_mult_signed (div_mult_signed),
        .hitoreg         (hitoreg),
        .lotoreg         (lotoreg),
        .jalr            (jalr),
        .div_mult_op     (div_mult_op)
    );

    opcode_decoder u_opcode (
        .state       (state),
        .opcode      (opcode),
        .branch_func (branch_func),
        .regjump     (regjump),
        .jalr        (jalr),
        .arith       (arith),
        .alu_op      (alu_op),
        .alu_src     (alu_src),
        .signed_imm  (signed_imm),
        .jump        (jump),
        .branch      (branch),
        .regdst      (regdst),
        .memtoreg    (memtoreg),
        .regtojump   (regtojump),
        .link        (link),
        .reg_link    (reg_link),
        .loadimmed   (loadimmed),
        .extend_op   (extend_op),
        .is_load     (is_load),
        .store_byte  (store_byte),
        .store_half  (store_half),
        .is_store    (is_store),
        .writes_reg  (writes_reg)
    );

    state_gate u_gate (
        .state         (state),
        .is_load       (is_load),
        .is_store      (is_store),
        .store_byte    (store_byte),
        .store_half    (store_half),
        .writes_reg    (writes_reg),
        .mult_div      (mult_div),
        .address_align (address_align),
        .memread       (memread),
        .memwrite      (memwrite),
        .regwrite      (regwrite),
        .inwrite       (inwrite),
        .pctoadd       (pctoadd),
        .div_mult_en   (div_mult_en),
        .bytewrite     (bytewrite),
        .halfwrite     (halfwrite),
        .byteenable    (byteenable)
    );

endmodule

`default_nettype wire

//--- control_unit_chk.sv
// Bound assertions on CPU state order, pcwrite timing and bus strobe exclusivity
`timescale 1ns/100ps
`default_nettype none

module control_unit_chk (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic                    memread,
    input wire logic                    memwrite,
    input wire logic                    pcwrite,
    input wire control_pkg::cpu_state_t state
);

    import control_pkg::*;

    no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(memread && memwrite)) else $error("memread and memwrite high together");
    pcwrite_exec2: assert property (@(posedge clk) disable iff (reset)
        pcwrite |-> state == exec2) else $error("pcwrite outside exec2");

    // Each state may only hold or move to its successor
    halt_step: assert property (@(posedge clk) disable iff (reset)
        state == halt |=> state == fetch) else $error("halt did not move to fetch");
    fetch_step: assert property (@(posedge clk) disable iff (reset)
        state == fetch |=> (state == fetch || state == decode)) else $error("fetch skipped");
    decode_step: assert property (@(posedge clk) disable iff (reset)
        state == decode |=> state == exec1) else $error("decode skipped");
    exec1_step: assert property (@(posedge clk) disable iff (reset)
        state == exec1 |=> (state == exec1 || state == exec2)) else $error("exec1 skipped");
    exec2_step: assert property (@(posedge clk) disable iff (reset)
        state == exec2 |=> (state == exec2 || state == fetch)) else $error("exec2 skipped");

endmodule

bind control_unit control_unit_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .memread  (memread),
    .memwrite (memwrite),
    .pcwrite  (pcwrite),
    .state    (state)
);

`default_nettype wire

//--- control_unit_tb.sv
// Control unit testbench with case file stimulus, random bus stalls and per-cycle output checks
`timescale 1ns/100ps
`default_nettype none

module control_unit_tb;

    import control_pkg::*;

    logic        clk;
    logic        reset;
    opcode_t     opcode;
    funct_t      fun;
    rt_field_t   branch_func;
    logic        waitrequest;
    logic [1:0]  address_align;
    byte_en_t    byteenable;
    logic        bytewrite;
    logic        halfwrite;
    alu_op_t     alu_op;
    logic        alu_src;
    logic        signed_imm;
    logic        jump;
    logic        branch;
    logic        memread;
    logic        memwrite;
    logic        regdst;
    logic        memtoreg;
    logic        regwrite;
    logic        inwrite;
    logic        pctoadd;
    logic        pcwrite;
    logic        regtojump;
    logic        div_mult_en;
    logic        div_mult_signed;
    md_op_t      div_mult_op;
    logic        hitoreg;
    logic        lotoreg;
    logic        link;
    logic        reg_link;
    logic        loadimmed;
    extend_op_t  extend_op;
    cpu_state_t  state;

    logic [31:0] rng;
    logic [31:0] col [22];      // Fields of the current case line
    string       case_lines[$];
    cpu_state_t  exp_state;
    int          errors;
    int          case_errors;
    int          timeout_cycles;
    logic        started;

    control_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog sized from the number of cases
    initial begin
        wait (started);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the cases did not finish within %0d clock cycles", timeout_cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
            case_errors++;
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    status;
        string line;
        fd = $fopen("control_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open control_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                if (status > 0 && line.len() > 1 && line[0] != "#") begin   // Skip header
                    case_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_outputs();
        logic       in_exec;
        logic [3:0] exp_be;
        logic       exp_bw;
        logic       exp_hw;
        in_exec = (exp_state == exec1) || (exp_state == exec2);
        exp_be  = 4'b1111;
        exp_bw  = 1'b0;
        exp_hw  = 1'b0;
        if (in_exec && col[21] == 32'd1) begin
            exp_be = 4'b0001 << address_align;
            exp_bw = 1'b1;
            exp_hw = 1'b1;
        end else if (in_exec && col[21] == 32'd2) begin
            exp_be = 4'b0011 << address_align;   // Top lane falls off at offset 3
            exp_hw = 1'b1;
        end
        check_value("state", 32'(state), 32'(exp_state));
        check_value("alu_op", 32'(alu_op), in_exec ? col[3] : 32'd0);
        check_value("alu_src", 32'(alu_src), in_exec ? col[4] : 32'd0);
        check_value("signed_imm", 32'(signed_imm), in_exec ? col[5] : 32'd0);
        check_value("jump", 32'(jump), in_exec ? col[6] : 32'd0);
        check_value("branch", 32'(branch), in_exec ? col[7] : 32'd0);
        check_value("regdst", 32'(regdst), in_exec ? col[8] : 32'd0);
        check_value("memtoreg", 32'(memtoreg), in_exec ? col[9] : 32'd0);
        check_value("regtojump", 32'(regtojump), in_exec ? col[10] : 32'd0);
        check_value("link", 32'(link), in_exec ? col[11] : 32'd0);
        check_value("reg_link", 32'(reg_link), in_exec ? col[12] : 32'd0);
        check_value("loadimmed", 32'(loadimmed), in_exec ? col[13] : 32'd0);
        check_value("extend_op", 32'(extend_op), in_exec ? col[14] : 32'd0);
        check_value("div_mult_op", 32'(div_mult_op), col[16]);   // Follows fun in every state
        check_value("div_mult_signed", 32'(div_mult_signed), col[17]);
        check_value("hitoreg", 32'(hitoreg), 32'(col[1] == 32'h10));   // MFHI funct code
        check_value("lotoreg", 32'(lotoreg), 32'(col[1] == 32'h12));   // MFLO funct code
        check_value("div_mult_en", 32'(div_mult_en), 32'(exp_state == exec1 && col[15] != 0));
        check_value("memread", 32'(memread),
                    32'(exp_state == fetch || (exp_state == exec1 && col[19] != 0)));
        check_value("memwrite", 32'(memwrite), 32'(exp_state == exec2 && col[20] != 0));
        check_value("regwrite", 32'(regwrite), 32'(exp_state == exec2 && col[18] != 0));
        check_value("inwrite", 32'(inwrite), 32'(exp_state == decode));
        check_value("pctoadd", 32'(pctoadd), 32'(exp_state == fetch || exp_state == decode));
        check_value("pcwrite", 32'(pcwrite), 32'(exp_state == exec2 && !waitrequest));
        check_value("byteenable", 32'(byteenable), 32'(exp_be));
        check_value("bytewrite", 32'(bytewrite), 32'(exp_bw));
        check_value("halfwrite", 32'(halfwrite), 32'(exp_hw));
    endtask

    task automatic run_case(input int idx);
        int         nread;
        int         cycles;
        logic       done;
        cpu_state_t next_state;
        case_errors = 0;
        cycles      = 0;
        done        = 1'b0;
        nread = $sscanf(case_lines[idx],
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9],
            col[10], col[11], col[12], col[13], col[14], col[15], col[16], col[17], col[18],
            col[19], col[20], col[21]);
        if (nread != 22) begin
            $display("case %0d: line has %0d fields where 22 are needed", idx, nread);
            errors++;
        end else begin
            opcode      = 6'(col[0]);
            fun         = 6'(col[1]);
            branch_func = 5'(col[2]);
            while (!done) begin
                rng           = xorshift32(rng);
                waitrequest   = (rng[3:2] == 2'b00);   // Stall about one cycle in four
                address_align = rng[9:8];
                #25;
                compare_outputs();
                case (exp_state)
                    fetch:   next_state = waitrequest ? fetch : decode;
                    decode:  next_state = exec1;
                    exec1:   next_state = (col[19] != 0 && waitrequest) ? exec1 : exec2;
                    exec2:   next_state = waitrequest ? exec2 : fetch;
                    default: next_state = fetch;
                endcase
                done      = (exp_state == exec2) && !waitrequest;
                exp_state = next_state;
                cycles++;
                @(negedge clk);
            end
            $display("case %0d op %h fun %h rt %h: %0d cycles, %0d errors",
                     idx, opcode, fun, branch_func, cycles, case_errors);
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset          = 1'b1;
        opcode         = '0;
        fun            = '0;
        branch_func    = '0;
        waitrequest    = 1'b0;
        address_align  = 2'b00;
        rng            = 32'd46487;
        errors         = 0;
        case_errors    = 0;
        timeout_cycles = 0;
        started        = 1'b0;
        exp_state      = halt;
        foreach (col[i]) begin
            col[i] = 32'd0;
        end
        load_cases();
        if (case_lines.size() == 0) begin
            $display("no cases were read from control_cases.txt");
            errors++;
        end else begin
            timeout_cycles = 18 + 32 * case_lines.size();
            started        = 1'b1;
            repeat (16) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            #25;
            compare_outputs();   // Halt with every strobe low
            $display("reset: %0d errors", case_errors);
            @(negedge clk);
            exp_state = fetch;
            for (int i = 0; i < case_lines.size(); i++) begin
                run_case(i);
            end
        end
        $display("%0d cases run, %0d errors", case_lines.size(), errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- control_cases.txt
# opcode fun rt alu_op alu_src signed_imm jump branch regdst memtoreg regtojump link reg_link loadimmed
# extend_op div_mult_en div_mult_op div_mult_signed writes_reg is_load is_store store_size(1 b,2 h,4 w)
00 21 00 2 0 0 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0 0
00 08 00 2 0 0 1 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0
00 09 00 2 0 0 1 0 1 0 1 1 1 0 0 0 0 0 1 0 0 0
00 18 00 2 0 0 0 0 1 0 0 0 0 0 0 1 2 1 0 0 0 0
00 1b 00 2 0 0 0 0 1 0 0 0 0 0 0 1 3 0 0 0 0 0
00 13 00 2 0 0 0 0 1 0 0 0 0 0 0 1 1 0 0 0 0 0
09 00 00 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0
0d 00 00 5 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0
0f 00 00 0 1 0 0 0 0 0 0 0 0 1 0 0 0 0 1 1 0 0
04 00 00 1 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
07 00 00 9 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
01 00 11 b 1 0 0 1 0 0 0 1 0 0 0 0 0 0 1 0 0 0
20 00 00 0 1 0 0 0 0 0 0 0 0 0 7 0 0 0 1 1 0 0
23 00 00 0 1 0 0 0 0 1 0 0 0 0 0 0 0 0 1 1 0 0
28 00 00 0 1 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1
29 00 00 0 1 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 2
2b 00 00 0 1 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 4
03 00 00 0 0 0 1 0 0 0 0 1 0 0 0 0 0 0 1 0 0 0

//--- tb.f
control_pkg.sv
cpu_state_seq.sv
funct_decoder.sv
opcode_decoder.sv
state_gate.sv
control_unit.sv
control_unit_chk.sv
control_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module control_unit_tb -o control_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/control_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
